// ==== hdl/snake_game_pkg.sv ====
package snake_game_pkg;

    localparam int SCORE_W = 8;

    typedef logic [SCORE_W-1:0] score_t;
    typedef logic [3:0] bcd_digit_t;                // one decimal digit.

    typedef enum logic [1:0] {
        IDLE,
        PLAY,
        OVER
    } game_state_t;

    // the round ends by itself once the score gets here.
    localparam score_t MAX_SCORE = 8'd140;

endpackage

// ==== hdl/seg_display_pkg.sv ====
package seg_display_pkg;

    localparam int NUM_DIGITS = 3;
    localparam int SCAN_DIV = 4;                    // clocks per digit step.
    localparam int SCAN_CNT_W = $clog2(SCAN_DIV);

    // active high, bit 6 is segment a and bit 0 is segment g.
    typedef logic [6:0] seg_t;

    // one-hot, bit 0 drives the ones digit.
    typedef logic [NUM_DIGITS-1:0] digit_en_t;

endpackage

// ==== hdl/score_ctrl_if.sv ====
`timescale 1ns/1ps

interface score_ctrl_if;

    logic playing;                                  // level, round in progress.
    logic clear;                                    // pulse, new round.
    logic game_end;                                 // pulse, round just ended.
    logic at_max;                                   // level, score at ceiling.

    modport fsm (
        output playing,
        output clear,
        output game_end,
        input  at_max
    );

    modport tracker (
        input  playing,
        input  clear,
        input  game_end,
        output at_max
    );

endinterface

// ==== hdl/game_fsm.sv ====
`timescale 1ns/1ps

module game_fsm (
    input  logic             clk,
    input  logic             nRst,
    input  logic             start,
    input  logic             bad_coll,
    score_ctrl_if.fsm        ctrl,
    output logic             game_over
);
    import snake_game_pkg::*;

    game_state_t state;
    game_state_t state_nxt;
    logic        clear_nxt;
    logic        game_end_nxt;

    always_comb begin
        state_nxt = state;
        clear_nxt = 1'b0;
        game_end_nxt = 1'b0;
        case (state)
            IDLE, OVER: begin
                if (start) begin
                    state_nxt = PLAY;
                    clear_nxt = 1'b1;
                end
            end
            PLAY: begin
                if (bad_coll || ctrl.at_max) begin  // start is ignored here.
                    state_nxt = OVER;
                    game_end_nxt = 1'b1;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state <= IDLE;
            ctrl.clear <= 1'b0;
            ctrl.game_end <= 1'b0;
        end else begin
            state <= state_nxt;
            ctrl.clear <= clear_nxt;                // high in the first PLAY cycle.
            ctrl.game_end <= game_end_nxt;          // high in the first OVER cycle.
        end
    end

    assign ctrl.playing = (state == PLAY);
    assign game_over = (state == OVER);

endmodule

// ==== hdl/score_tracker.sv ====
`timescale 1ns/1ps

module score_tracker (
    input  logic                    clk,
    input  logic                    nRst,
    input  logic                    good_coll,
    score_ctrl_if.tracker           ctrl,
    output snake_game_pkg::score_t  current_score,
    output snake_game_pkg::score_t  disp_score
);
    import snake_game_pkg::*;

    logic   good_prev;
    logic   good_edge;
    logic   at_max_q;
    score_t score_nxt;
    score_t high_score;

    assign good_edge = good_coll && !good_prev;     // a held level scores once.

    always_comb begin
        score_nxt = current_score;
        if (ctrl.clear) begin
            score_nxt = '0;
        end else if (ctrl.playing && good_edge && (current_score < MAX_SCORE)) begin
            score_nxt = current_score + 1'b1;
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            good_prev <= 1'b0;
            current_score <= '0;
            high_score <= '0;
        end else begin
            good_prev <= good_coll;
            current_score <= score_nxt;
            if (score_nxt > high_score) begin
                high_score <= score_nxt;            // moves with the score.
            end
        end
    end

    // ceiling request to the FSM, dropped once the round is over
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            at_max_q <= 1'b0;
        end else if (ctrl.game_end) begin
            at_max_q <= 1'b0;
        end else if (ctrl.playing && (score_nxt >= MAX_SCORE)) begin
            at_max_q <= 1'b1;
        end
    end

    assign ctrl.at_max = at_max_q;

    assign disp_score = ctrl.playing ? current_score : high_score;

endmodule

// ==== hdl/bcd_encoder.sv ====
`timescale 1ns/1ps

module bcd_encoder (
    input  logic                        clk,
    input  logic                        nRst,
    input  snake_game_pkg::score_t      value,
    output snake_game_pkg::bcd_digit_t  ones,
    output snake_game_pkg::bcd_digit_t  tens,
    output snake_game_pkg::bcd_digit_t  hundreds
);
    import snake_game_pkg::*;

    score_t     rem;
    bcd_digit_t hundreds_nxt;
    bcd_digit_t tens_nxt;

    always_comb begin
        rem = value;
        hundreds_nxt = '0;
        tens_nxt = '0;
        for (int i = 0; i < 2; i++) begin           // at most 255.
            if (rem >= 8'd100) begin
                rem = rem - 8'd100;
                hundreds_nxt = hundreds_nxt + 4'd1;
            end
        end
        for (int i = 0; i < 9; i++) begin
            if (rem >= 8'd10) begin
                rem = rem - 8'd10;
                tens_nxt = tens_nxt + 4'd1;
            end
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            ones <= '0;
            tens <= '0;
            hundreds <= '0;
        end else begin
            ones <= rem[3:0];                       // remainder is below ten.
            tens <= tens_nxt;
            hundreds <= hundreds_nxt;
        end
    end

endmodule

// ==== hdl/scan_timer.sv ====
`timescale 1ns/1ps

module scan_timer (
    input  logic clk,
    input  logic nRst,
    output logic scan_tick
);
    import seg_display_pkg::*;

    logic [SCAN_CNT_W-1:0] cnt;
    logic                  wrap;

    assign wrap = (cnt == SCAN_CNT_W'(SCAN_DIV - 1));

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            cnt <= '0;
        end else if (wrap) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign scan_tick = wrap;                        // one cycle in SCAN_DIV.

endmodule

// ==== hdl/digit_scanner.sv ====
`timescale 1ns/1ps

module digit_scanner (
    input  logic                        clk,
    input  logic                        nRst,
    input  logic                        scan_tick,
    input  snake_game_pkg::bcd_digit_t  ones,
    input  snake_game_pkg::bcd_digit_t  tens,
    input  snake_game_pkg::bcd_digit_t  hundreds,
    output seg_display_pkg::seg_t       seg,
    output seg_display_pkg::digit_en_t  digit_en
);
    import snake_game_pkg::*;
    import seg_display_pkg::*;

    bcd_digit_t digit;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            digit_en <= digit_en_t'(1);             // ones digit first.
        end else if (scan_tick) begin
            digit_en <= {digit_en[NUM_DIGITS-2:0], digit_en[NUM_DIGITS-1]};
        end
    end

    always_comb begin
        digit = ones;
        if (digit_en[1]) begin
            digit = tens;
        end else if (digit_en[2]) begin
            digit = hundreds;
        end
    end

    always_comb begin
        case (digit)                                // abcdefg.
            4'd0:    seg = 7'b1111110;
            4'd1:    seg = 7'b0110000;
            4'd2:    seg = 7'b1101101;
            4'd3:    seg = 7'b1111001;
            4'd4:    seg = 7'b0110011;
            4'd5:    seg = 7'b1011011;
            4'd6:    seg = 7'b1011111;
            4'd7:    seg = 7'b1110000;
            4'd8:    seg = 7'b1111111;
            4'd9:    seg = 7'b1111011;
            default: seg = 7'b0000000;              // blank on bad digits.
        endcase
    end

endmodule

// ==== hdl/snake_score_top.sv ====
`timescale 1ns/1ps

module snake_score_top (
    input  logic                        clk,
    input  logic                        nRst,
    input  logic                        start,
    input  logic                        good_coll,
    input  logic                        bad_coll,
    output snake_game_pkg::score_t      current_score,
    output snake_game_pkg::score_t      disp_score,
    output snake_game_pkg::bcd_digit_t  bcd_ones,
    output snake_game_pkg::bcd_digit_t  bcd_tens,
    output snake_game_pkg::bcd_digit_t  bcd_hundreds,
    output logic                        game_over,
    output seg_display_pkg::seg_t       seg,
    output seg_display_pkg::digit_en_t  digit_en
);

    logic scan_tick;

    score_ctrl_if ctrl_if ();

    game_fsm game_fsm_i (
        .clk       (clk),
        .nRst      (nRst),
        .start     (start),
        .bad_coll  (bad_coll),
        .ctrl      (ctrl_if.fsm),
        .game_over (game_over)
    );

    score_tracker score_tracker_i (
        .clk           (clk),
        .nRst          (nRst),
        .good_coll     (good_coll),
        .ctrl          (ctrl_if.tracker),
        .current_score (current_score),
        .disp_score    (disp_score)
    );

    bcd_encoder bcd_encoder_i (
        .clk      (clk),
        .nRst     (nRst),
        .value    (disp_score),
        .ones     (bcd_ones),
        .tens     (bcd_tens),
        .hundreds (bcd_hundreds)
    );

    scan_timer scan_timer_i (
        .clk       (clk),
        .nRst      (nRst),
        .scan_tick (scan_tick)
    );

    digit_scanner digit_scanner_i (
        .clk       (clk),
        .nRst      (nRst),
        .scan_tick (scan_tick),
        .ones      (bcd_ones),
        .tens      (bcd_tens),
        .hundreds  (bcd_hundreds),
        .seg       (seg),
        .digit_en  (digit_en)
    );

endmodule

// ==== verification/snake_score_tb.sv ====
`timescale 1ns/1ps

module snake_score_tb;
    import snake_game_pkg::*;
    import seg_display_pkg::*;

    localparam int NUM_ROWS = 9;
    localparam int RAND_N = -1;                     // pulse count drawn from the LFSR.
    localparam int MODEL = -1;                      // expected value taken from the model.

    typedef struct packed {
        logic start;
        int   n_good;
        int   hold;
        logic bad;
        int   exp_cur;
        int   exp_disp;
        int   exp_over;
        int   exp_high;
    } row_t;

    logic       clk = 1'b0;
    logic       nRst;
    logic       start;
    logic       good_coll;
    logic       bad_coll;
    score_t     current_score;
    score_t     disp_score;
    bcd_digit_t bcd_ones;
    bcd_digit_t bcd_tens;
    bcd_digit_t bcd_hundreds;
    logic       game_over;
    seg_t       seg;
    digit_en_t  digit_en;

    row_t        rows [NUM_ROWS];
    logic [31:0] lfsr = 32'hdb06_bfca;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          model_cur = 0;
    int          model_high = 0;
    bit          model_playing = 1'b0;
    bit          model_over = 1'b0;
    int          last_disp = 0;

    always #5 clk = ~clk;

    snake_score_top snake_score_top_i (
        .clk           (clk),
        .nRst          (nRst),
        .start         (start),
        .good_coll     (good_coll),
        .bad_coll      (bad_coll),
        .current_score (current_score),
        .disp_score    (disp_score),
        .bcd_ones      (bcd_ones),
        .bcd_tens      (bcd_tens),
        .bcd_hundreds  (bcd_hundreds),
        .game_over     (game_over),
        .seg           (seg),
        .digit_en      (digit_en)
    );

    function automatic logic [31:0] step_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = step_lfsr(lfsr);
            val = (val << 1) | int'(lfsr[0]);
        end
    endtask

    // segments a to g, a in bit 6.
    function automatic seg_t seg_pattern(input int d);
        case (d)
            0:       return 7'b1111110;
            1:       return 7'b0110000;
            2:       return 7'b1101101;
            3:       return 7'b1111001;
            4:       return 7'b0110011;
            5:       return 7'b1011011;
            6:       return 7'b1011111;
            7:       return 7'b1110000;
            8:       return 7'b1111111;
            9:       return 7'b1111011;
            default: return 7'b0000000;
        endcase
    endfunction

    function automatic int onehot_index(input digit_en_t en);
        case (en)
            3'b001:  return 0;
            3'b010:  return 1;
            3'b100:  return 2;
            default: return -1;
        endcase
    endfunction

    function automatic int cycle_budget();
        int total;
        int n;
        total = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            n = (rows[i].n_good == RAND_N) ? 32 : rows[i].n_good;
            total += n * (rows[i].hold + 1) + 2;
            if (rows[i].start) total += 2;
            if (rows[i].bad) total += 2;
        end
        return total + 5 * SCAN_DIV + 100;          // scan check plus margin.
    endfunction

    task automatic load_table();
        rows[0] = '{1'b0, 3, 1, 1'b0, 0, 0, 0, 0};                      // no round yet.
        rows[1] = '{1'b1, 5, 1, 1'b0, 5, 5, 0, 5};
        rows[2] = '{1'b0, 2, 4, 1'b0, 7, 7, 0, 7};                      // held pulses.
        rows[3] = '{1'b0, RAND_N, 1, 1'b1, MODEL, MODEL, 1, MODEL};
        rows[4] = '{1'b1, 0, 1, 1'b0, 0, 0, 0, MODEL};                  // restart clears.
        rows[5] = '{1'b0, 4, 2, 1'b1, 4, MODEL, 1, MODEL};
        rows[6] = '{1'b1, RAND_N, 1, 1'b0, MODEL, MODEL, 0, MODEL};
        rows[7] = '{1'b1, 2, 1, 1'b1, MODEL, MODEL, 1, MODEL};          // start mid round.
        rows[8] = '{1'b1, 150, 1, 1'b0, 140, 140, 1, 140};              // hits the ceiling.
    endtask

    task automatic check_value(input string what, input int got, input int exp);
        assert (got == exp) else begin
            $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int first_err);
        tests_run++;
        if (errors == first_err) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d checks failed", name, errors - first_err);
        end
    endtask

    task automatic pulse_good(input int hold);
        good_coll = 1'b1;
        repeat (hold) @(negedge clk);
        good_coll = 1'b0;
        @(negedge clk);
        if (model_playing && model_cur < int'(MAX_SCORE)) begin
            model_cur++;
        end
        if (model_cur > model_high) begin
            model_high = model_cur;
        end
        if (model_playing && model_cur == int'(MAX_SCORE)) begin
            model_playing = 1'b0;                   // ceiling ends the round.
            model_over = 1'b1;
        end
    endtask

    task automatic check_reset();
        int first_err;
        first_err = errors;
        check_value("current_score", int'(current_score), 0);
        check_value("disp_score", int'(disp_score), 0);
        check_value("bcd_ones", int'(bcd_ones), 0);
        check_value("bcd_tens", int'(bcd_tens), 0);
        check_value("bcd_hundreds", int'(bcd_hundreds), 0);
        check_value("game_over", int'(game_over), 0);
        check_value("digit_en", int'(digit_en), 1);
        report_test("reset", first_err);
    endtask

    task automatic apply_row(input int idx);
        row_t r;
        int   n;
        int   first_err;
        int   exp_cur;
        int   exp_disp;
        int   exp_over;
        r = rows[idx];
        first_err = errors;
        n = r.n_good;
        if (n == RAND_N) begin
            take_bits(5, n);
            n = n + 1;
        end
        if (r.start) begin
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            @(negedge clk);                         // clear cycle.
            if (!model_playing) begin
                model_playing = 1'b1;
                model_over = 1'b0;
                model_cur = 0;
            end
        end
        for (int i = 0; i < n; i++) begin
            pulse_good(r.hold);
        end
        if (r.bad) begin
            bad_coll = 1'b1;
            @(negedge clk);
            bad_coll = 1'b0;
            @(negedge clk);                         // one edge after the display switched.
            if (model_playing) begin
                model_playing = 1'b0;
                model_over = 1'b1;
            end
            check_value("bcd_hundreds", int'(bcd_hundreds), model_high / 100);
            check_value("bcd_tens", int'(bcd_tens), (model_high / 10) % 10);
            check_value("bcd_ones", int'(bcd_ones), model_high % 10);
        end
        repeat (2) @(negedge clk);
        exp_cur = (r.exp_cur == MODEL) ? model_cur : r.exp_cur;
        exp_disp = (r.exp_disp == MODEL) ? (model_playing ? model_cur : model_high) : r.exp_disp;
        exp_over = (r.exp_over == MODEL) ? int'(model_over) : r.exp_over;
        check_value("current_score", int'(current_score), exp_cur);
        check_value("disp_score", int'(disp_score), exp_disp);
        check_value("game_over", int'(game_over), exp_over);
        if (exp_over != 0) begin
            check_value("high score", int'(disp_score),
                        (r.exp_high == MODEL) ? model_high : r.exp_high);
        end
        check_value("bcd_hundreds", int'(bcd_hundreds), exp_disp / 100);
        check_value("bcd_tens", int'(bcd_tens), (exp_disp / 10) % 10);
        check_value("bcd_ones", int'(bcd_ones), exp_disp % 10);
        last_disp = exp_disp;
        report_test($sformatf("row %0d, %0d good pulses", idx, n), first_err);
    endtask

    task automatic check_scan();
        int        first_err;
        int        idx;
        int        waited;
        int        digits [NUM_DIGITS];
        digit_en_t prev;
        bit        advanced;
        first_err = errors;
        digits[0] = last_disp % 10;
        digits[1] = (last_disp / 10) % 10;
        digits[2] = last_disp / 100;
        prev = digit_en;
        idx = onehot_index(prev);
        waited = 0;
        while (digit_en == prev && waited < 2 * SCAN_DIV) begin
            @(negedge clk);
            waited++;
        end
        advanced = (idx >= 0) && (digit_en != prev);
        assert (advanced) else begin
            $display("scan: digit enable is not one-hot or never advanced");
            errors++;
        end
        if (advanced) begin
            for (int step = 0; step < NUM_DIGITS; step++) begin
                if (step > 0) begin
                    repeat (SCAN_DIV) @(negedge clk);
                end
                idx = (idx + 1) % NUM_DIGITS;
                check_value("digit_en", int'(digit_en), 1 << idx);
                check_value("seg", int'(seg), int'(seg_pattern(digits[idx])));
            end
        end
        report_test("display scan", first_err);
    endtask

    initial begin
        nRst = 1'b0;
        start = 1'b0;
        good_coll = 1'b0;
        bad_coll = 1'b0;
        load_table();
        repeat (3) @(negedge clk);
        nRst = 1'b1;
        check_reset();
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(i);
        end
        check_scan();
        $display("tests: %0d run, %0d failed, %0d failed checks",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog
    initial begin
        @(posedge nRst);
        repeat (cycle_budget()) @(posedge clk);
        $display("timeout: the run took longer than %0d cycles", cycle_budget());
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== snake_score_top.f ====
hdl/snake_game_pkg.sv
hdl/seg_display_pkg.sv
hdl/score_ctrl_if.sv
hdl/game_fsm.sv
hdl/score_tracker.sv
hdl/bcd_encoder.sv
hdl/scan_timer.sv
hdl/digit_scanner.sv
hdl/snake_score_top.sv
verification/snake_score_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP    ?= snake_score_tb
RTL_TOP   ?= snake_score_top
FILELIST  ?= snake_score_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
